// File: common/rv_core_pkg.sv
package rv_core_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;

    // Register index from x0 to x31
    typedef logic [4:0] reg_addr_t;

    // Byte enables of one word
    typedef logic [3:0] ben_t;

    // Retirement counter of the trace port
    typedef logic [63:0] order_t;

    // Source of the value written in WB
    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LOAD
    } wb_src_e;

endpackage

// File: common/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// PC after reset
`define RESET_PC 32'h0000_0000

// Base opcodes of the supported RV32I subset
`define OPC_LUI    7'b0110111
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`endif

// File: core/core.sv
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module core (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    output rv_core_pkg::word_t     imem_addr_o,
    input  rv_core_pkg::word_t     imem_rdata_i,
    output rv_core_pkg::word_t     dmem_addr_o,
    output rv_core_pkg::word_t     dmem_wdata_o,
    output logic                   dmem_wen_o,
    output rv_core_pkg::ben_t      dmem_ben_o,
    input  rv_core_pkg::word_t     dmem_rdata_i,
    output logic                   valid_ex_o,
    output rv_core_pkg::word_t     insn_ex_o,
    output rv_core_pkg::word_t     pc_ex_o,
    output rv_core_pkg::word_t     next_pc_ex_o,
    output logic                   trap_ex_o,
    output logic                   valid_wb_o,
    output rv_core_pkg::reg_addr_t rd_addr_wb_o,
    output logic                   reg_wen_wb_o,
    output rv_core_pkg::word_t     reg_wdata_wb_o
);
    import rv_core_pkg::*;

    word_t      pc_q;
    logic       valid_ex_q;
    word_t      insn_ex_q;
    word_t      pc_ex_q;
    logic       valid_wb_q;
    reg_addr_t  rd_wb_q;
    wb_src_e    wb_src_q;
    word_t      alu_wb_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rf_rs1;
    word_t      rf_rs2;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_i;
    word_t      imm_s;
    word_t      alu_res;
    word_t      target;
    wb_src_e    wb_src_ex;
    logic       trap;
    logic       is_store;
    logic       taken;
    logic       use_rs1;
    logic       use_rs2;
    logic       stall;

    assign opcode   = insn_ex_q[6:0];
    assign funct3   = insn_ex_q[14:12];
    assign rs1_addr = insn_ex_q[19:15];
    assign rs2_addr = insn_ex_q[24:20];
    assign imm_i    = {{20{insn_ex_q[31]}}, insn_ex_q[31:20]};
    assign imm_s    = {{20{insn_ex_q[31]}}, insn_ex_q[31:25], insn_ex_q[11:7]};

    regfile regfile_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_wb_q),
        .wen_i      (reg_wen_wb_o),
        .wdata_i    (reg_wdata_wb_o),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    // WB result forwarded into EX
    assign rs1_val = (reg_wen_wb_o && rd_wb_q == rs1_addr) ? reg_wdata_wb_o : rf_rs1;
    assign rs2_val = (reg_wen_wb_o && rd_wb_q == rs2_addr) ? reg_wdata_wb_o : rf_rs2;

    always_comb begin
        alu_res   = pc_ex_q + 32'd4;
        wb_src_ex = WB_NONE;
        trap      = 1'b0;
        is_store  = 1'b0;
        taken     = 1'b0;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        target    = pc_ex_q + {{19{insn_ex_q[31]}}, insn_ex_q[31], insn_ex_q[7],
                               insn_ex_q[30:25], insn_ex_q[11:8], 1'b0};
        case (opcode)
            `OPC_LUI: begin
                alu_res   = {insn_ex_q[31:12], 12'b0};
                wb_src_ex = WB_ALU;
                use_rs1   = 1'b0;
            end
            `OPC_OPIMM: begin
                alu_res   = rs1_val + imm_i;
                wb_src_ex = WB_ALU;
                trap      = funct3 != 3'b000;
            end
            `OPC_OP: begin
                wb_src_ex = WB_ALU;
                use_rs2   = 1'b1;
                case ({insn_ex_q[31:25], funct3})
                    10'b0000000_000: alu_res = rs1_val + rs2_val;
                    10'b0100000_000: alu_res = rs1_val - rs2_val;
                    10'b0000000_100: alu_res = rs1_val ^ rs2_val;
                    10'b0000000_110: alu_res = rs1_val | rs2_val;
                    10'b0000000_111: alu_res = rs1_val & rs2_val;
                    default:         trap    = 1'b1;
                endcase
            end
            `OPC_LOAD: begin
                wb_src_ex = WB_LOAD;
                trap      = funct3 != 3'b010;
            end
            `OPC_STORE: begin
                use_rs2  = 1'b1;
                is_store = 1'b1;
                trap     = funct3 != 3'b010;
            end
            `OPC_BRANCH: begin
                use_rs2 = 1'b1;
                // funct3[0] turns BEQ into BNE
                taken   = (rs1_val == rs2_val) ^ funct3[0];
                trap    = funct3[2:1] != 2'b00;
            end
            `OPC_JAL: begin
                wb_src_ex = WB_ALU;
                taken     = 1'b1;
                use_rs1   = 1'b0;
                target    = pc_ex_q + {{11{insn_ex_q[31]}}, insn_ex_q[31], insn_ex_q[19:12],
                                       insn_ex_q[20], insn_ex_q[30:21], 1'b0};
            end
            default: begin
                trap    = 1'b1;
                use_rs1 = 1'b0;
            end
        endcase
        // Trapped instruction has no side effects
        if (trap) begin
            wb_src_ex = WB_NONE;
            is_store  = 1'b0;
            taken     = 1'b0;
        end
    end

    // Load-use hazard while the load sits in WB
    assign stall = valid_ex_q && reg_wen_wb_o && wb_src_q == WB_LOAD
                   && ((use_rs1 && rs1_addr == rd_wb_q) || (use_rs2 && rs2_addr == rd_wb_q));

    assign valid_ex_o   = valid_ex_q && !stall;
    assign insn_ex_o    = insn_ex_q;
    assign pc_ex_o      = pc_ex_q;
    assign next_pc_ex_o = taken ? target : pc_ex_q + 32'd4;
    assign trap_ex_o    = trap;

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = rs1_val + (is_store ? imm_s : imm_i);
    assign dmem_wdata_o = rs2_val;
    assign dmem_wen_o   = valid_ex_o && is_store;
    assign dmem_ben_o   = dmem_wen_o ? 4'b1111 : 4'b0000;

    // A taken branch or jump drops the fetched word
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `RESET_PC;
            valid_ex_q <= 1'b0;
        end else if (valid_ex_o && taken) begin
            pc_q       <= target;
            valid_ex_q <= 1'b0;
        end else if (!stall) begin
            pc_q       <= pc_q + 32'd4;
            valid_ex_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            insn_ex_q <= imem_rdata_i;
            pc_ex_q   <= pc_q;
        end
    end

    // A stall sends a bubble on to WB
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_wb_q <= 1'b0;
        end else begin
            valid_wb_q <= valid_ex_o;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_wb_q  <= insn_ex_q[11:7];
        wb_src_q <= wb_src_ex;
        alu_wb_q <= alu_res;
    end

    assign valid_wb_o     = valid_wb_q;
    assign rd_addr_wb_o   = rd_wb_q;
    assign reg_wen_wb_o   = valid_wb_q && wb_src_q != WB_NONE && rd_wb_q != '0;
    assign reg_wdata_wb_o = (wb_src_q == WB_LOAD) ? dmem_rdata_i : alu_wb_q;

    // A store moves on to WB next cycle and writes no register
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dmem_wen_o |-> valid_ex_q ##1 (valid_wb_q && !reg_wen_wb_o));

    // An x0 operand reads zero whatever sits in WB
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (valid_ex_q && rs1_addr == '0) |-> rs1_val == '0);
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (valid_ex_q && rs2_addr == '0) |-> rs2_val == '0);

endmodule

// File: core/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  rv_core_pkg::reg_addr_t rs2_addr_i,
    input  rv_core_pkg::reg_addr_t rd_addr_i,
    input  logic                   wen_i,
    input  rv_core_pkg::word_t     wdata_i,
    output rv_core_pkg::word_t     rs1_data_o,
    output rv_core_pkg::word_t     rs2_data_o
);
    import rv_core_pkg::*;

    // x0 has no storage
    word_t regs_q [1:31];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && rd_addr_i != '0) begin
            regs_q[rd_addr_i] <= wdata_i;
        end
    end

    // Same-cycle write is forwarded by the core
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the rvfi_wrapper testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rvfi_core.f \
    --top-module tb_rvfi_wrapper -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST OK" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: rvfi_core.f
+incdir+common
common/rv_core_pkg.sv
core/regfile.sv
core/core.sv
src/rvfi.sv
src/rvfi_wrapper.sv
testbench/tb_rvfi_wrapper.sv

// File: src/rvfi.sv
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rvfi (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   valid_ex_i,
    input  rv_core_pkg::word_t     insn_ex_i,
    input  rv_core_pkg::word_t     pc_ex_i,
    input  rv_core_pkg::word_t     next_pc_ex_i,
    input  logic                   trap_ex_i,
    input  rv_core_pkg::word_t     mem_addr_ex_i,
    input  rv_core_pkg::word_t     mem_wdata_ex_i,
    input  rv_core_pkg::ben_t      mem_ben_ex_i,
    input  logic                   valid_wb_i,
    input  rv_core_pkg::reg_addr_t rd_addr_wb_i,
    input  logic                   reg_wen_wb_i,
    input  rv_core_pkg::word_t     reg_wdata_wb_i,
    output logic                   rvfi_valid_o,
    output rv_core_pkg::order_t    rvfi_order_o,
    output rv_core_pkg::word_t     rvfi_insn_o,
    output logic                   rvfi_trap_o,
    output rv_core_pkg::word_t     rvfi_pc_rdata_o,
    output rv_core_pkg::word_t     rvfi_pc_wdata_o,
    output rv_core_pkg::reg_addr_t rvfi_rd_addr_o,
    output rv_core_pkg::word_t     rvfi_rd_wdata_o,
    output rv_core_pkg::word_t     rvfi_mem_addr_o,
    output rv_core_pkg::ben_t      rvfi_mem_wmask_o,
    output rv_core_pkg::word_t     rvfi_mem_wdata_o
);
    import rv_core_pkg::*;

    word_t hold_insn_q;
    word_t hold_pc_q;
    word_t hold_next_pc_q;
    logic  hold_trap_q;
    word_t hold_addr_q;
    word_t hold_wdata_q;
    ben_t  hold_wmask_q;
    logic  is_store;

    // Memory fields only carry meaning for a store
    assign is_store = insn_ex_i[6:0] == `OPC_STORE && !trap_ex_i;

    // EX fields held until the instruction reaches WB
    always_ff @(posedge clk_i) begin
        if (valid_ex_i) begin
            hold_insn_q    <= insn_ex_i;
            hold_pc_q      <= pc_ex_i;
            hold_next_pc_q <= next_pc_ex_i;
            hold_trap_q    <= trap_ex_i;
            hold_addr_q    <= is_store ? mem_addr_ex_i : '0;
            hold_wdata_q   <= is_store ? mem_wdata_ex_i : '0;
            hold_wmask_q   <= is_store ? mem_ben_ex_i : '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvfi_valid_o <= 1'b0;
            rvfi_order_o <= '0;
        end else begin
            rvfi_valid_o <= valid_wb_i;
            if (rvfi_valid_o) begin
                rvfi_order_o <= rvfi_order_o + 64'd1;
            end
        end
    end

    // Record assembled in the WB cycle
    always_ff @(posedge clk_i) begin
        if (valid_wb_i) begin
            rvfi_insn_o      <= hold_insn_q;
            rvfi_trap_o      <= hold_trap_q;
            rvfi_pc_rdata_o  <= hold_pc_q;
            rvfi_pc_wdata_o  <= hold_next_pc_q;
            rvfi_mem_addr_o  <= hold_addr_q;
            rvfi_mem_wdata_o <= hold_wdata_q;
            rvfi_mem_wmask_o <= hold_wmask_q;
            rvfi_rd_addr_o   <= reg_wen_wb_i ? rd_addr_wb_i : '0;
            rvfi_rd_wdata_o  <= reg_wen_wb_i ? reg_wdata_wb_i : '0;
        end
    end

    // Traps and stores retire without a register write
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rvfi_valid_o && (rvfi_trap_o || rvfi_mem_wmask_o != '0))
        |-> (rvfi_rd_addr_o == '0 && rvfi_rd_wdata_o == '0));

    // Order steps by one after each retirement and holds otherwise
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvfi_valid_o |=> rvfi_order_o == $past(rvfi_order_o) + 64'd1);
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !rvfi_valid_o |=> $stable(rvfi_order_o));

endmodule

// File: src/rvfi_wrapper.sv
`timescale 1ns/1ns

module rvfi_wrapper (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    output rv_core_pkg::word_t     imem_addr_o,
    input  rv_core_pkg::word_t     imem_rdata_i,
    output rv_core_pkg::word_t     dmem_addr_o,
    output rv_core_pkg::word_t     dmem_wdata_o,
    output logic                   dmem_wen_o,
    output rv_core_pkg::ben_t      dmem_ben_o,
    input  rv_core_pkg::word_t     dmem_rdata_i,
    output logic                   rvfi_valid_o,
    output rv_core_pkg::order_t    rvfi_order_o,
    output rv_core_pkg::word_t     rvfi_insn_o,
    output logic                   rvfi_trap_o,
    output rv_core_pkg::word_t     rvfi_pc_rdata_o,
    output rv_core_pkg::word_t     rvfi_pc_wdata_o,
    output rv_core_pkg::reg_addr_t rvfi_rd_addr_o,
    output rv_core_pkg::word_t     rvfi_rd_wdata_o,
    output rv_core_pkg::word_t     rvfi_mem_addr_o,
    output rv_core_pkg::ben_t      rvfi_mem_wmask_o,
    output rv_core_pkg::word_t     rvfi_mem_wdata_o
);
    import rv_core_pkg::*;

    // Trace signals from core to tracer
    logic      valid_ex;
    word_t     insn_ex;
    word_t     pc_ex;
    word_t     next_pc_ex;
    logic      trap_ex;
    logic      valid_wb;
    reg_addr_t rd_addr_wb;
    logic      reg_wen_wb;
    word_t     reg_wdata_wb;

    core core_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_wen_o     (dmem_wen_o),
        .dmem_ben_o     (dmem_ben_o),
        .dmem_rdata_i   (dmem_rdata_i),
        .valid_ex_o     (valid_ex),
        .insn_ex_o      (insn_ex),
        .pc_ex_o        (pc_ex),
        .next_pc_ex_o   (next_pc_ex),
        .trap_ex_o      (trap_ex),
        .valid_wb_o     (valid_wb),
        .rd_addr_wb_o   (rd_addr_wb),
        .reg_wen_wb_o   (reg_wen_wb),
        .reg_wdata_wb_o (reg_wdata_wb)
    );

    rvfi rvfi_inst (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .valid_ex_i       (valid_ex),
        .insn_ex_i        (insn_ex),
        .pc_ex_i          (pc_ex),
        .next_pc_ex_i     (next_pc_ex),
        .trap_ex_i        (trap_ex),
        .mem_addr_ex_i    (dmem_addr_o),
        .mem_wdata_ex_i   (dmem_wdata_o),
        .mem_ben_ex_i     (dmem_ben_o),
        .valid_wb_i       (valid_wb),
        .rd_addr_wb_i     (rd_addr_wb),
        .reg_wen_wb_i     (reg_wen_wb),
        .reg_wdata_wb_i   (reg_wdata_wb),
        .rvfi_valid_o     (rvfi_valid_o),
        .rvfi_order_o     (rvfi_order_o),
        .rvfi_insn_o      (rvfi_insn_o),
        .rvfi_trap_o      (rvfi_trap_o),
        .rvfi_pc_rdata_o  (rvfi_pc_rdata_o),
        .rvfi_pc_wdata_o  (rvfi_pc_wdata_o),
        .rvfi_rd_addr_o   (rvfi_rd_addr_o),
        .rvfi_rd_wdata_o  (rvfi_rd_wdata_o),
        .rvfi_mem_addr_o  (rvfi_mem_addr_o),
        .rvfi_mem_wmask_o (rvfi_mem_wmask_o),
        .rvfi_mem_wdata_o (rvfi_mem_wdata_o)
    );

endmodule

// File: testbench/rvfi_stim.mem
// Program image from word 000, record count at word 100, records from word 101
// Record: pc insn next_pc rd rd_data flags mem_addr mem_wmask mem_wdata
// flags bit 0 marks a load whose rd_data column is its address, bit 1 a trap
@000
123450B7 67808093 FFF00113 002081B3
40118233 001242B3 0051F3B3 0013E333
04102023 04002403 008404B3 08002503
04902423 00140663 00100593 00200593
00419463 00300593 00418463 00C0066F
00400593 00500593 00500013 01200693
000012F3 00C28733 0000006F
@100
00000016
00 123450B7 04 01 12345000 0 00 0 00000000
04 67808093 08 01 12345678 0 00 0 00000000
08 FFF00113 0C 02 FFFFFFFF 0 00 0 00000000
0C 002081B3 10 03 12345677 0 00 0 00000000
10 40118233 14 04 FFFFFFFF 0 00 0 00000000
14 001242B3 18 05 EDCBA987 0 00 0 00000000
18 0051F3B3 1C 07 00000007 0 00 0 00000000
1C 0013E333 20 06 1234567F 0 00 0 00000000
20 04102023 24 00 00000000 0 40 F 12345678
24 04002403 28 08 12345678 0 00 0 00000000
28 008404B3 2C 09 2468ACF0 0 00 0 00000000
2C 08002503 30 0A 00000080 1 00 0 00000000
30 04902423 34 00 00000000 0 48 F 2468ACF0
34 00140663 40 00 00000000 0 00 0 00000000
40 00419463 48 00 00000000 0 00 0 00000000
48 00418463 4C 00 00000000 0 00 0 00000000
4C 00C0066F 58 0C 00000050 0 00 0 00000000
58 00500013 5C 00 00000000 0 00 0 00000000
5C 01200693 60 0D 00000012 0 00 0 00000000
60 000012F3 64 00 00000000 2 00 0 00000000
64 00C28733 68 0E EDCBA9D7 0 00 0 00000000
68 0000006F 68 00 00000000 0 00 0 00000000

// File: testbench/tb_rvfi_wrapper.sv
`timescale 1ns/1ns

module tb_rvfi_wrapper;
    import rv_core_pkg::*;

    // Layout of the stim image
    localparam int COUNT_WORD = 'h100;
    localparam int REC_BASE   = 'h101;
    localparam int REC_WORDS  = 9;
    localparam int WAIT_LIMIT = 50;

    logic      clk;
    logic      arst_n;
    word_t     imem_addr;
    word_t     imem_rdata;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_wen;
    ben_t      dmem_ben;
    word_t     dmem_rdata;
    logic      rvfi_valid;
    order_t    rvfi_order;
    word_t     rvfi_insn;
    logic      rvfi_trap;
    word_t     rvfi_pc_rdata;
    word_t     rvfi_pc_wdata;
    reg_addr_t rvfi_rd_addr;
    word_t     rvfi_rd_wdata;
    word_t     rvfi_mem_addr;
    ben_t      rvfi_mem_wmask;
    word_t     rvfi_mem_wdata;

    word_t     stim_words [0:511];
    word_t     dmem [0:63];
    integer    seed;

    rvfi_wrapper dut0 (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .imem_addr_o      (imem_addr),
        .imem_rdata_i     (imem_rdata),
        .dmem_addr_o      (dmem_addr),
        .dmem_wdata_o     (dmem_wdata),
        .dmem_wen_o       (dmem_wen),
        .dmem_ben_o       (dmem_ben),
        .dmem_rdata_i     (dmem_rdata),
        .rvfi_valid_o     (rvfi_valid),
        .rvfi_order_o     (rvfi_order),
        .rvfi_insn_o      (rvfi_insn),
        .rvfi_trap_o      (rvfi_trap),
        .rvfi_pc_rdata_o  (rvfi_pc_rdata),
        .rvfi_pc_wdata_o  (rvfi_pc_wdata),
        .rvfi_rd_addr_o   (rvfi_rd_addr),
        .rvfi_rd_wdata_o  (rvfi_rd_wdata),
        .rvfi_mem_addr_o  (rvfi_mem_addr),
        .rvfi_mem_wmask_o (rvfi_mem_wmask),
        .rvfi_mem_wdata_o (rvfi_mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Program section of the stim image read combinationally
    assign imem_rdata = stim_words[imem_addr[9:2]];

    // Data memory takes the EX request mid-cycle and answers after the edge
    initial begin
        word_t req_addr;
        word_t req_wdata;
        logic  req_wen;
        ben_t  req_ben;
        dmem_rdata = '0;
        seed = 69803;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        forever begin
            @(negedge clk);
            req_addr  = dmem_addr;
            req_wdata = dmem_wdata;
            req_wen   = dmem_wen;
            req_ben   = dmem_ben;
            @(posedge clk);
            #1;
            if (req_wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_ben[b]) begin
                        dmem[req_addr[7:2]][8*b +: 8] = req_wdata[8*b +: 8];
                    end
                end
            end
            dmem_rdata = dmem[req_addr[7:2]];
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_order(input string name, input order_t got, input order_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_ben(input string name, input ben_t got, input ben_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // Trace outputs are looked at on the falling edge
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rvfi_valid !== 1'b1) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("no instruction retired within %0d cycles, at %0t ns",
                                    WAIT_LIMIT, $time));
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int    n_rec;
        int    base;
        word_t exp_rd_data;
        arst_n = 1'b0;
        for (int i = 0; i < 512; i++) begin
            stim_words[i] = '0;
        end
        $readmemh("testbench/rvfi_stim.mem", stim_words);
        n_rec = int'(stim_words[COUNT_WORD]);
        if (n_rec == 0) begin
            abort_run("the stim file holds no expected retirements");
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int r = 0; r < n_rec; r++) begin
            base = REC_BASE + r * REC_WORDS;
            wait_retire();
            // Load data comes from the memory model at the given address
            if (stim_words[base + 5][0]) begin
                exp_rd_data = dmem[stim_words[base + 4][7:2]];
            end else begin
                exp_rd_data = stim_words[base + 4];
            end
            check_order("rvfi_order_o", rvfi_order, order_t'(r));
            check_word("rvfi_pc_rdata_o", rvfi_pc_rdata, stim_words[base]);
            check_word("rvfi_insn_o", rvfi_insn, stim_words[base + 1]);
            check_word("rvfi_pc_wdata_o", rvfi_pc_wdata, stim_words[base + 2]);
            check_reg("rvfi_rd_addr_o", rvfi_rd_addr, stim_words[base + 3][4:0]);
            check_word("rvfi_rd_wdata_o", rvfi_rd_wdata, exp_rd_data);
            check_flag("rvfi_trap_o", rvfi_trap, stim_words[base + 5][1]);
            check_word("rvfi_mem_addr_o", rvfi_mem_addr, stim_words[base + 6]);
            check_ben("rvfi_mem_wmask_o", rvfi_mem_wmask, stim_words[base + 7][3:0]);
            check_word("rvfi_mem_wdata_o", rvfi_mem_wdata, stim_words[base + 8]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule
